// File: rtl/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

  // Scan counter width
  localparam int unsigned scan_width = 10;

  ////////////////////////////////////////////////////////////
  // Horizontal, in pixel periods
  localparam int unsigned h_total        = 800;
  localparam int unsigned h_sync_end     = 96;
  localparam int unsigned h_active_first = 144;
  localparam int unsigned h_active_last  = 783;

  ////////////////////////////////////////////////////////////
  // Vertical, in lines
  localparam int unsigned v_total        = 525;
  localparam int unsigned v_sync_lines   = 1;
  localparam int unsigned v_active_first = 35;
  localparam int unsigned v_active_last  = 514;

endpackage

`default_nettype wire

// File: rtl/board_pkg.sv
`default_nettype none

package board_pkg;

  // Board size
  localparam int unsigned board_rows    = 20;
  localparam int unsigned board_cols    = 10;
  localparam int unsigned row_idx_width = 5;
  localparam int unsigned col_idx_width = 4;

  ////////////////////////////////////////////////////////////
  // Cell placement in scan coordinates
  localparam int unsigned cell_size    = 24;
  localparam int unsigned grid_x_first = 345;
  localparam int unsigned grid_y_first = 35;
  localparam int unsigned grid_x_last  = grid_x_first + board_cols * cell_size - 1;
  localparam int unsigned grid_y_last  = grid_y_first + board_rows * cell_size - 1;

  // Border bars, two pixels wide
  localparam int unsigned border_width   = 2;
  localparam int unsigned border_left_x  = 342;
  localparam int unsigned border_right_x = 584;
  localparam int unsigned border_y_first = 35;
  localparam int unsigned border_y_last  = 513;

  ////////////////////////////////////////////////////////////
  // Wishbone widths
  localparam int unsigned wb_adr_width = 5;
  localparam int unsigned wb_dat_width = 16;

  // Colour words, 4 bits per channel
  localparam int unsigned colour_width = 12;
  localparam int unsigned chan_width   = 4;
  localparam logic [colour_width-1:0] colour_cell   = 12'h00F;
  localparam logic [colour_width-1:0] colour_border = 12'h00C;
  localparam logic [colour_width-1:0] colour_black  = 12'h000;

  typedef union packed {
    logic [colour_width-1:0] raw;
    struct packed {
      logic [chan_width-1:0] red;
      logic [chan_width-1:0] green;
      logic [chan_width-1:0] blue;
    } ch;
  } pixel_word_t;

endpackage

`default_nettype wire

// File: rtl/board_regs.sv
`timescale 1ns/1ps
`default_nettype none

module board_regs
  import board_pkg::*;
(
  input  wire                      clk_n,
  input  wire                      clr,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire [wb_adr_width-1:0]   wb_adr,
  input  wire [wb_dat_width-1:0]   wb_dat_w,
  output logic [wb_dat_width-1:0]  wb_dat_r,
  output logic                     wb_ack,
  input  wire [row_idx_width-1:0]  row_sel,
  output logic [board_cols-1:0]    row_bits
);

  logic [board_cols-1:0] rows [board_rows];
  logic                  access;
  logic                  in_range;

  // New request only while no ack is pending
  assign access   = wb_cyc && wb_stb && !wb_ack;
  assign in_range = (wb_adr < board_rows);

  ////////////////////////////////////////////////////////////
  // Host side
  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      for (int i = 0; i < board_rows; i++) begin
        rows[i] <= '0;
      end
    end else begin
      wb_ack <= access;
      if (access && wb_we && in_range) begin
        rows[wb_adr] <= wb_dat_w[board_cols-1:0];
      end
      if (access && !wb_we) begin
        // Out of range reads as zero
        if (in_range) begin
          wb_dat_r <= wb_dat_width'(rows[wb_adr]);
        end else begin
          wb_dat_r <= '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Scan side, combinational lookup
  always_comb begin
    if (row_sel < board_rows) begin
      row_bits = rows[row_sel];
    end else begin
      row_bits = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/scan_timing.sv
`timescale 1ns/1ps
`default_nettype none

module scan_timing
  import vga_timing_pkg::*;
(
  input  wire                     clk_n,
  input  wire                     clr,
  output logic [scan_width-1:0]   scan_x,
  output logic [scan_width-1:0]   scan_y,
  output logic                    hsync,
  output logic                    vsync
);

  logic line_end;
  logic frame_end;

  assign line_end  = (scan_x == scan_width'(h_total - 1));
  assign frame_end = (scan_y == scan_width'(v_total - 1));

  ////////////////////////////////////////////////////////////
  // Column and line counters
  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      scan_x <= '0;
      scan_y <= '0;
    end else if (line_end) begin
      scan_x <= '0;
      if (frame_end) begin
        scan_y <= '0;
      end else begin
        scan_y <= scan_y + 1'b1;
      end
    end else begin
      scan_x <= scan_x + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sync pulses, one cycle behind the counters
  // so they line up with the registered colour
  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      // Active low during the sync interval
      hsync <= (scan_x >= scan_width'(h_sync_end));
      vsync <= (scan_y >= scan_width'(v_sync_lines));
    end
  end

endmodule

`default_nettype wire

// File: rtl/cell_locator.sv
`timescale 1ns/1ps
`default_nettype none

module cell_locator
  import vga_timing_pkg::*;
  import board_pkg::*;
(
  input  wire [scan_width-1:0]      scan_x,
  input  wire [scan_width-1:0]      scan_y,
  output logic [row_idx_width-1:0]  row_sel,
  output logic [col_idx_width-1:0]  col_sel,
  output logic                      in_grid,
  output logic                      on_border
);

  logic [scan_width-1:0] dx;
  logic [scan_width-1:0] dy;
  logic                  visible;
  logic                  x_in;
  logic                  y_in;
  logic                  left_bar;
  logic                  right_bar;
  logic                  bar_lines;

  // Nothing is drawn in blanking
  assign visible = (scan_x >= h_active_first) && (scan_x <= h_active_last) &&
                   (scan_y >= v_active_first) && (scan_y <= v_active_last);

  ////////////////////////////////////////////////////////////
  // Cell lookup
  assign dx   = scan_x - scan_width'(grid_x_first);
  assign dy   = scan_y - scan_width'(grid_y_first);
  assign x_in = (scan_x >= grid_x_first) && (scan_x <= grid_x_last);
  assign y_in = (scan_y >= grid_y_first) && (scan_y <= grid_y_last);

  assign in_grid = visible && x_in && y_in;
  assign col_sel = in_grid ? col_idx_width'(dx / cell_size) : '0;
  assign row_sel = in_grid ? row_idx_width'(dy / cell_size) : '0;

  ////////////////////////////////////////////////////////////
  // Border bars
  assign left_bar  = (scan_x >= border_left_x) &&
                     (scan_x < border_left_x + border_width);
  assign right_bar = (scan_x >= border_right_x) &&
                     (scan_x < border_right_x + border_width);
  assign bar_lines = (scan_y >= border_y_first) && (scan_y <= border_y_last);

  assign on_border = visible && bar_lines && (left_bar || right_bar);

endmodule

`default_nettype wire

// File: rtl/pixel_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_stage
  import board_pkg::*;
(
  input  wire                      clk_n,
  input  wire                      clr,
  input  wire [board_cols-1:0]     row_bits,
  input  wire [col_idx_width-1:0]  col_sel,
  input  wire                      in_grid,
  input  wire                      on_border,
  output logic [chan_width-1:0]    red,
  output logic [chan_width-1:0]    green,
  output logic [chan_width-1:0]    blue
);

  pixel_word_t next_word;
  pixel_word_t pixel_q;

  // Lit cell wins over the right bar where they overlap
  always_comb begin
    if (in_grid && row_bits[col_sel]) begin
      next_word.raw = colour_cell;
    end else if (on_border) begin
      next_word.raw = colour_border;
    end else begin
      next_word.raw = colour_black;
    end
  end

  always_ff @(posedge clk_n or posedge clr) begin
    if (clr) begin
      pixel_q.raw <= colour_black;
    end else begin
      pixel_q <= next_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Channel split
  assign red   = pixel_q.ch.red;
  assign green = pixel_q.ch.green;
  assign blue  = pixel_q.ch.blue;

endmodule

`default_nettype wire

// File: rtl/vga_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_top
  import vga_timing_pkg::*;
  import board_pkg::*;
(
  input  wire                      clk_n,
  input  wire                      clr,
  // Wishbone classic slave
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire [wb_adr_width-1:0]   wb_adr,
  input  wire [wb_dat_width-1:0]   wb_dat_w,
  output logic [wb_dat_width-1:0]  wb_dat_r,
  output logic                     wb_ack,
  // Display
  output logic                     hsync,
  output logic                     vsync,
  output logic [chan_width-1:0]    red,
  output logic [chan_width-1:0]    green,
  output logic [chan_width-1:0]    blue
);

  logic [scan_width-1:0]    scan_x;
  logic [scan_width-1:0]    scan_y;
  logic [row_idx_width-1:0] row_sel;
  logic [col_idx_width-1:0] col_sel;
  logic [board_cols-1:0]    row_bits;
  logic                     in_grid;
  logic                     on_border;

  ////////////////////////////////////////////////////////////
  // Board storage
  board_regs regs_i (
    .clk_n    (clk_n),
    .clr      (clr),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .row_sel  (row_sel),
    .row_bits (row_bits)
  );

  ////////////////////////////////////////////////////////////
  // Scan and lookup
  scan_timing timing_i (
    .clk_n  (clk_n),
    .clr    (clr),
    .scan_x (scan_x),
    .scan_y (scan_y),
    .hsync  (hsync),
    .vsync  (vsync)
  );

  cell_locator locator_i (
    .scan_x    (scan_x),
    .scan_y    (scan_y),
    .row_sel   (row_sel),
    .col_sel   (col_sel),
    .in_grid   (in_grid),
    .on_border (on_border)
  );

  ////////////////////////////////////////////////////////////
  // Colour out
  pixel_stage pixel_i (
    .clk_n     (clk_n),
    .clr       (clr),
    .row_bits  (row_bits),
    .col_sel   (col_sel),
    .in_grid   (in_grid),
    .on_border (on_border),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

`default_nettype wire

// File: verif/scan_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module scan_asserts
  import vga_timing_pkg::*;
(
  input wire                  clk_n,
  input wire                  clr,
  input wire                  ack,
  input wire [scan_width-1:0] x_pos,
  input wire [scan_width-1:0] y_pos
);

  // Acknowledge is a single-cycle pulse
  ack_single: assert property (@(posedge clk_n) disable iff (clr) ack |=> !ack)
    else $error("wb_ack stayed high for two cycles");

  ////////////////////////////////////////////////////////////
  // Counter ranges
  col_range: assert property (@(posedge clk_n) disable iff (clr)
                              x_pos <= scan_width'(h_total - 1))
    else $error("Scan column went past the last column of the line");

  line_range: assert property (@(posedge clk_n) disable iff (clr)
                               y_pos <= scan_width'(v_total - 1))
    else $error("Scan line went past the last line of the frame");

endmodule

// Host side only sees the acknowledge
bind board_regs scan_asserts regs_chk_i (
  .clk_n (clk_n),
  .clr   (clr),
  .ack   (wb_ack),
  .x_pos ('0),
  .y_pos ('0)
);

bind scan_timing scan_asserts timing_chk_i (
  .clk_n (clk_n),
  .clr   (clr),
  .ack   (1'b0),
  .x_pos (scan_x),
  .y_pos (scan_y)
);

`default_nettype wire

// File: verif/tb_vga_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_top
  import vga_timing_pkg::*;
  import board_pkg::*;
();

  localparam longint frame_cycles = h_total * v_total;
  localparam int     clk_period   = 40;
  localparam int     ack_limit    = 16;

  logic                    clk_n;
  logic                    clr;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [wb_adr_width-1:0] wb_adr;
  logic [wb_dat_width-1:0] wb_dat_w;
  logic [wb_dat_width-1:0] wb_dat_r;
  logic                    wb_ack;
  logic                    hsync;
  logic                    vsync;
  logic [chan_width-1:0]   red;
  logic [chan_width-1:0]   green;
  logic [chan_width-1:0]   blue;

  longint edges;
  bit     loaded;
  int     pix_count;
  byte    cmd_kind[$];
  int     cmd_a[$];
  int     cmd_b[$];
  int     cmd_c[$];
  int     cmd_d[$];
  int     cmd_e[$];

  vga_top dut_i (
    .clk_n    (clk_n),
    .clr      (clr),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .hsync    (hsync),
    .vsync    (vsync),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  initial begin
    clk_n = 1'b0;
    forever #(clk_period / 2) clk_n = ~clk_n;
  end

  // Edges since reset release, i.e. the scan position in the DUT
  always @(posedge clk_n or posedge clr) begin
    if (clr) begin
      edges <= 0;
    end else begin
      edges <= edges + 1;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Run stopped");
  endtask

  ////////////////////////////////////////////////////////////
  // Tests file
  task automatic load_tests();
    int    fd;
    int    n;
    string text;
    string tag;
    int    a;
    int    b;
    int    c;
    int    d;
    int    e;
    fd = $fopen("verif/board_tests.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the tests file verif/board_tests.txt");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (text.len() < 2 || text.getc(0) == "#") begin
        continue;
      end
      c = 0;
      d = 0;
      e = 0;
      if (text.getc(0) == "P") begin
        n = $sscanf(text, "%s %d %d %h %d %d", tag, a, b, c, d, e);
        pix_count++;
        if (n != 6) begin
          stop_run($sformatf("Malformed pixel command in tests file: %s", text));
        end
      end else if (text.getc(0) == "W" || text.getc(0) == "R") begin
        n = $sscanf(text, "%s %d %h", tag, a, b);
        if (n != 3) begin
          stop_run($sformatf("Malformed bus command in tests file: %s", text));
        end
      end else begin
        stop_run($sformatf("Unknown command in tests file: %s", text));
      end
      cmd_kind.push_back(text.getc(0));
      cmd_a.push_back(a);
      cmd_b.push_back(b);
      cmd_c.push_back(c);
      cmd_d.push_back(d);
      cmd_e.push_back(e);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone master, called and returning on a falling edge
  task automatic wb_access(input bit we, input int adr, input int dat,
                           output logic [wb_dat_width-1:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = wb_adr_width'(adr);
    wb_dat_w = wb_dat_width'(dat);
    waited   = 0;
    do begin
      @(negedge clk_n);
      waited++;
      if (waited > ack_limit) begin
        stop_run($sformatf("No Wishbone acknowledge for address %0d", adr));
      end
    end while (!wb_ack);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk_n);
    assert (!wb_ack) else
      stop_run($sformatf("[ERROR] %0t ns: second acknowledge at address %0d", $time, adr));
  endtask

  // Outputs lag the scan by one cycle
  task automatic check_pixel(input int x, input int y, input int col, input int hs, input int vs);
    longint                  target;
    logic [colour_width-1:0] got;
    target = (edges / frame_cycles) * frame_cycles + longint'(y) * h_total + x + 1;
    if (target < edges) begin
      target += frame_cycles;
    end
    while (edges < target) begin
      @(negedge clk_n);
    end
    got = {red, green, blue};
    assert (got == colour_width'(col)) else
      stop_run($sformatf("[ERROR] %0t ns: pixel (%0d,%0d) colour %03h, expected %03h",
                         $time, x, y, got, colour_width'(col)));
    assert (hsync == hs[0] && vsync == vs[0]) else
      stop_run($sformatf("[ERROR] %0t ns: pixel (%0d,%0d) sync %b%b, expected %b%b",
                         $time, x, y, hsync, vsync, hs[0], vs[0]));
  endtask

  initial begin
    logic [wb_dat_width-1:0] rdata;
    clr       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    pix_count = 0;
    loaded    = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (16) @(negedge clk_n);
    clr = 1'b0;
    for (int i = 0; i < cmd_kind.size(); i++) begin
      if (cmd_kind[i] == "W") begin
        wb_access(1'b1, cmd_a[i], cmd_b[i], rdata);
      end else if (cmd_kind[i] == "R") begin
        wb_access(1'b0, cmd_a[i], 0, rdata);
        assert (rdata == wb_dat_width'(cmd_b[i])) else
          stop_run($sformatf("[ERROR] %0t ns: read of address %0d gave %04h, expected %04h",
                             $time, cmd_a[i], rdata, wb_dat_width'(cmd_b[i])));
      end else begin
        check_pixel(cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i], cmd_e[i]);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

  // Each pixel check waits at most one frame
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(pix_count) + 2) * frame_cycles * clk_period;
    #(limit_ns);
    $display("The run took longer than %0d ns and was stopped", limit_ns);
    $display("Finished with errors");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/vga_timing_pkg.sv
rtl/board_pkg.sv
rtl/board_regs.sv
rtl/scan_timing.sv
rtl/cell_locator.sv
rtl/pixel_stage.sv
rtl/vga_top.sv
verif/scan_asserts.sv
verif/tb_vga_top.sv

// File: Makefile
SHELL := /bin/bash
TOP   := tb_vga_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f vlog.f -o sim_$(TOP)
	set -o pipefail; ./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: verif/board_tests.txt
# W <addr dec> <data hex>   R <addr dec> <expected hex>
# P <column dec> <line dec> <expected colour hex> <hsync> <vsync>
W 0 FE01
W 5 04A5
W 12 1150
W 19 8201
W 7 03FF
R 7 03FF
W 7 0000
W 20 FFFF
W 31 03FF
R 0 0201
R 5 00A5
R 12 0150
R 19 0201
R 7 0000
R 3 0000
R 4 0000
R 15 0000
R 20 0000
R 31 0000
# Pixel checks in raster order
P 95 0 000 0 0
P 96 0 000 1 0
P 345 0 000 1 0
P 799 0 000 1 0
P 0 1 000 0 1
P 345 34 000 1 1
P 342 35 00C 1 1
P 343 35 00C 1 1
P 344 35 000 1 1
P 345 35 00F 1 1
P 584 35 00F 1 1
P 585 35 00C 1 1
P 586 35 000 1 1
P 369 40 000 1 1
P 578 50 00F 1 1
P 400 160 00F 1 1
P 430 160 000 1 1
P 470 170 00F 1 1
P 520 178 00F 1 1
P 540 178 000 1 1
P 350 210 000 1 1
P 343 300 00C 1 1
P 585 300 00C 1 1
P 441 323 00F 1 1
P 465 330 000 1 1
P 500 340 00F 1 1
P 560 346 00F 1 1
P 368 500 00F 1 1
P 369 500 000 1 1
P 342 513 00C 1 1
P 585 513 00C 1 1
P 342 514 000 1 1
P 345 514 00F 1 1
P 584 514 00F 1 1
P 585 514 000 1 1
P 345 515 000 1 1
P 50 524 000 0 1
